//--- clk_mon_pkg.sv
// shared register types and address map for the clock monitor, imported by its modules

`default_nettype none

package clk_mon_pkg;

  // ************************************************************
  // bus vector types
  // ************************************************************

  // register address as seen on the strobe bus
  typedef logic [7:0] reg_addr_t;

  // register read and write data
  typedef logic [31:0] reg_data_t;

  // ************************************************************
  // address map
  // ************************************************************

  // each group spans max_channels words, channel n sits at base + n
  localparam int max_channels = 16;

  // captured counts, read only
  localparam reg_addr_t addr_count_base = 8'h00;

  // lower limits, read/write
  localparam reg_addr_t addr_low_base = 8'h10;

  // upper limits, read/write
  localparam reg_addr_t addr_high_base = 8'h20;

  // sticky alarm bits, one per channel
  // writing a one clears the bit
  localparam reg_addr_t addr_status = 8'h30;

endpackage

`default_nettype wire

//--- clk_mon_counter.sv
// one-channel frequency measurement, counts meas_clk edges over a fixed d_clk window

`timescale 1ns/1ps
`default_nettype none

module clk_mon_counter #(
  parameter int window_width = 16,
  parameter int count_width = 24
) (
  input  wire logic                   d_clk,
  input  wire logic                   d_rst,
  input  wire logic                   meas_clk,
  output logic [count_width-1:0]      count,
  output logic                        update
);

  // first value of the window counter, so run stays high for 2^window_width cycles
  localparam logic [window_width-1:0] win_first = 1;

  // ************************************************************
  // reference side, d_clk
  // ************************************************************

  logic [window_width-1:0]  win_cnt;
  logic                     win_end;
  logic                     run;
  logic                     running_m1;
  logic                     running_m2;
  logic                     running_m3;
  logic                     capture;
  logic                     dead_clear;
  logic [count_width-1:0]   cap_value;

  // ************************************************************
  // monitored side, meas_clk
  // ************************************************************

  logic                     m_rst_m1;
  logic                     m_rst;
  logic                     run_m1;
  logic                     run_m2;
  logic                     run_m3;
  logic                     m_start;
  logic [count_width:0]     m_count;

  // window wraps back to zero on its last cycle
  assign win_end = (win_cnt == '0);

  // falling edge of the returned running level
  assign capture = running_m3 & ~running_m2;

  // window ran out and the monitored side never answered
  assign dead_clear = win_end & ~running_m3;

  // overflow flag set means the count went past all ones
  assign cap_value = m_count[count_width] ? '1 : m_count[count_width-1:0];

  // running level back from the monitored domain
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      running_m1 <= 1'b0;
      running_m2 <= 1'b0;
      running_m3 <= 1'b0;
    end else begin
      running_m1 <= run_m3;
      running_m2 <= running_m1;
      running_m3 <= running_m2;
    end
  end

  // run opens whenever running is low and closes at the window wrap
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      run <= 1'b0;
    end else if (!running_m3) begin
      run <= 1'b1;
    end else if (win_end) begin
      run <= 1'b0;
    end
  end

  // window counter restarts while run is low
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      win_cnt <= win_first;
    end else if (!run) begin
      win_cnt <= win_first;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // capture result, or zero for a stopped clock
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      count  <= '0;
      update <= 1'b0;
    end else begin
      update <= capture | dead_clear;
      if (capture) begin
        count <= cap_value;
      end else if (dead_clear) begin
        count <= '0;
      end
    end
  end

  // local reset, set at once by d_rst and released after two meas_clk edges
  always_ff @(posedge meas_clk or posedge d_rst) begin
    if (d_rst) begin
      m_rst_m1 <= 1'b1;
      m_rst    <= 1'b1;
    end else begin
      m_rst_m1 <= 1'b0;
      m_rst    <= m_rst_m1;
    end
  end

  // run into the monitored domain
  always_ff @(posedge meas_clk or posedge m_rst) begin
    if (m_rst) begin
      run_m1 <= 1'b0;
      run_m2 <= 1'b0;
      run_m3 <= 1'b0;
    end else begin
      run_m1 <= run;
      run_m2 <= run_m1;
      run_m3 <= run_m2;
    end
  end

  // rising edge of run starts a new count
  assign m_start = run_m2 & ~run_m3;

  // edge counter, sticks at all ones once the top bit is reached
  always_ff @(posedge meas_clk) begin
    if (m_start) begin
      m_count <= '0;
    end else if (run_m3) begin
      if (!m_count[count_width]) begin
        m_count <= m_count + 1'b1;
      end else begin
        m_count <= '1;
      end
    end
  end

endmodule

`default_nettype wire

//--- clk_mon_regs.sv
// register file of the clock monitor, limits, counts, sticky alarms and the read port

`timescale 1ns/1ps
`default_nettype none

module clk_mon_regs
  import clk_mon_pkg::*;
#(
  parameter int num_channels = 2,
  parameter int count_width = 24
) (
  input  wire logic                                d_clk,
  input  wire logic                                d_rst,
  input  wire logic                                rd,
  input  wire logic                                wr,
  input  wire reg_addr_t                           addr,
  input  wire reg_data_t                           wr_data,
  output reg_data_t                                rd_data,
  input  wire logic [num_channels*count_width-1:0] counts,
  input  wire logic [num_channels-1:0]             updates,
  output logic                                     irq
);

  // low address bits pick the channel inside a group
  localparam int ch_bits = $clog2(max_channels);

  reg_addr_t                 addr_grp;
  logic [ch_bits-1:0]        addr_ch;
  logic                      status_hit;
  logic [count_width-1:0]    cnt [num_channels];
  logic [count_width-1:0]    low_lim [num_channels];
  logic [count_width-1:0]    high_lim [num_channels];
  logic [num_channels-1:0]   alarm;
  logic [num_channels-1:0]   alarm_set;
  logic [num_channels-1:0]   alarm_clr;
  reg_data_t                 rd_value;

  // ************************************************************
  // address decode
  // ************************************************************

  assign addr_grp   = addr & ~reg_addr_t'(max_channels - 1);
  assign addr_ch    = addr[ch_bits-1:0];
  assign status_hit = (addr == addr_status);

  // split the packed count vector per channel
  always_comb begin
    for (int i = 0; i < num_channels; i++) begin
      cnt[i] = counts[i*count_width +: count_width];
    end
  end

  // ************************************************************
  // limit registers
  // ************************************************************

  // defaults never trip an alarm
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      for (int i = 0; i < num_channels; i++) begin
        low_lim[i]  <= '0;
        high_lim[i] <= '1;
      end
    end else if (wr) begin
      for (int i = 0; i < num_channels; i++) begin
        if (int'(addr_ch) == i && addr_grp == addr_low_base) begin
          low_lim[i] <= wr_data[count_width-1:0];
        end
        if (int'(addr_ch) == i && addr_grp == addr_high_base) begin
          high_lim[i] <= wr_data[count_width-1:0];
        end
      end
    end
  end

  // ************************************************************
  // alarms and interrupt
  // ************************************************************

  // a fresh count outside its window
  always_comb begin
    for (int i = 0; i < num_channels; i++) begin
      alarm_set[i] = updates[i] & ((cnt[i] < low_lim[i]) | (cnt[i] > high_lim[i]));
    end
  end

  assign alarm_clr = (wr && status_hit) ? wr_data[num_channels-1:0] : '0;

  // set beats a clear landing on the same edge
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      alarm <= '0;
      irq   <= 1'b0;
    end else begin
      alarm <= (alarm & ~alarm_clr) | alarm_set;
      irq   <= |alarm;
    end
  end

  // ************************************************************
  // read port
  // ************************************************************

  // channels past num_channels and unmapped words fall through as zero
  always_comb begin
    rd_value = '0;
    if (status_hit) begin
      rd_value = reg_data_t'(alarm);
    end
    for (int i = 0; i < num_channels; i++) begin
      if (int'(addr_ch) == i) begin
        if (addr_grp == addr_count_base) begin
          rd_value = reg_data_t'(cnt[i]);
        end else if (addr_grp == addr_low_base) begin
          rd_value = reg_data_t'(low_lim[i]);
        end else if (addr_grp == addr_high_base) begin
          rd_value = reg_data_t'(high_lim[i]);
        end
      end
    end
  end

  // read data holds until the next rd strobe
  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      rd_data <= '0;
    end else if (rd) begin
      rd_data <= rd_value;
    end
  end

endmodule

`default_nettype wire

//--- clk_mon_top.sv
// clock frequency monitor top, one measurement block per clock plus the register file

`timescale 1ns/1ps
`default_nettype none

module clk_mon_top
  import clk_mon_pkg::*;
#(
  parameter int num_channels = 2,
  parameter int window_width = 16,
  parameter int count_width = 24
) (
  input  wire logic                    d_clk,
  input  wire logic                    d_rst,
  input  wire logic [num_channels-1:0] meas_clk,
  input  wire logic                    rd,
  input  wire logic                    wr,
  input  wire reg_addr_t               addr,
  input  wire reg_data_t               wr_data,
  output reg_data_t                    rd_data,
  output logic                         irq
);

  // captured counts, channel n in bits n*count_width upward
  logic [num_channels*count_width-1:0] counts;

  // one pulse per channel when its count is refreshed
  logic [num_channels-1:0]             updates;

  // ************************************************************
  // measurement blocks
  // ************************************************************

  for (genvar g = 0; g < num_channels; g++) begin : g_chan
    clk_mon_counter #(
      .window_width (window_width),
      .count_width  (count_width)
    ) i_clk_mon_counter (
      .d_clk    (d_clk),
      .d_rst    (d_rst),
      .meas_clk (meas_clk[g]),
      .count    (counts[g*count_width +: count_width]),
      .update   (updates[g])
    );
  end

  // ************************************************************
  // register file
  // ************************************************************

  clk_mon_regs #(
    .num_channels (num_channels),
    .count_width  (count_width)
  ) i_clk_mon_regs (
    .d_clk   (d_clk),
    .d_rst   (d_rst),
    .rd      (rd),
    .wr      (wr),
    .addr    (addr),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .counts  (counts),
    .updates (updates),
    .irq     (irq)
  );

endmodule

`default_nettype wire

//--- clk_mon_props.sv
// bus and interrupt assertions, bound into the clock monitor top for simulation

`timescale 1ns/1ps
`default_nettype none

module clk_mon_props
  import clk_mon_pkg::*;
#(
  parameter int num_channels = 2
) (
  input wire logic                    d_clk,
  input wire logic                    d_rst,
  input wire logic                    rd,
  input wire logic                    wr,
  input wire reg_data_t               rd_data,
  input wire logic                    irq,
  input wire logic [num_channels-1:0] updates
);

  // failures seen so far, read by the testbench at the end
  int fail_count = 0;

  // ************************************************************
  // interrupt
  // ************************************************************

  // reset holds irq low
  a_irq_in_reset: assert property (@(posedge d_clk) d_rst |-> !irq)
    else begin
      fail_count++;
      $error("irq high while reset is asserted");
    end

  // irq only rises two cycles after a count update raised an alarm
  a_irq_after_update: assert property (@(posedge d_clk) disable iff (d_rst)
    $rose(irq) |-> $past(|updates, 2))
    else begin
      fail_count++;
      $error("irq rose without a count update two cycles before");
    end

  // ************************************************************
  // register bus
  // ************************************************************

  a_rd_wr_apart: assert property (@(posedge d_clk) !(rd && wr))
    else begin
      fail_count++;
      $error("rd and wr strobes high together");
    end

  // read data only moves on a read strobe
  a_rd_data_hold: assert property (@(posedge d_clk) disable iff (d_rst)
    !$past(rd) |-> $stable(rd_data))
    else begin
      fail_count++;
      $error("rd_data changed without a read strobe");
    end

endmodule

bind clk_mon_top clk_mon_props #(
  .num_channels (num_channels)
) i_clk_mon_props (
  .d_clk   (d_clk),
  .d_rst   (d_rst),
  .rd      (rd),
  .wr      (wr),
  .rd_data (rd_data),
  .irq     (irq),
  .updates (updates)
);

`default_nettype wire

//--- clk_mon_tb.sv
// testbench for the clock monitor top, run from the file list with clk_mon_tb as top

`timescale 1ns/1ps
`default_nettype none

module clk_mon_tb
  import clk_mon_pkg::*;
();

  localparam int num_channels = 3;
  localparam int window_width = 8;
  localparam int count_width = 10;

  // clock periods in ns
  localparam int d_period = 100;
  localparam int m0_period = 40;
  localparam int m1_period = 20;

  localparam int win_cycles = 1 << window_width;
  localparam int count_max = (1 << count_width) - 1;

  // one measurement is a window plus synchronizer latency, with margin
  localparam int update_wait = 2 * win_cycles + 64;
  localparam int watchdog_cycles = 20 * win_cycles;

  logic                    d_clk;
  logic                    d_rst;
  logic [num_channels-1:0] meas_clk;
  logic                    rd;
  logic                    wr;
  reg_addr_t               addr;
  reg_data_t               wr_data;
  reg_data_t               rd_data;
  logic                    irq;

  int                      errors;
  logic [15:0]             lfsr_state;
  logic [count_width-1:0]  low_val;
  logic [count_width-1:0]  high_val;

  clk_mon_top #(
    .num_channels (num_channels),
    .window_width (window_width),
    .count_width  (count_width)
  ) i_clk_mon_top (
    .d_clk    (d_clk),
    .d_rst    (d_rst),
    .meas_clk (meas_clk),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .wr_data  (wr_data),
    .rd_data  (rd_data),
    .irq      (irq)
  );

  // ************************************************************
  // clocks
  // ************************************************************

  always #(d_period / 2) d_clk = ~d_clk;
  always #(m0_period / 2) meas_clk[0] = ~meas_clk[0];
  always #(m1_period / 2) meas_clk[1] = ~meas_clk[1];
  // meas_clk[2] never toggles, it stands for a dead clock

  // ************************************************************
  // random limits
  // ************************************************************

  // galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // ************************************************************
  // bus tasks, entered and left 1 ns after a rising edge
  // ************************************************************

  task automatic idle(input int n);
    repeat (n) @(posedge d_clk);
    #1;
  endtask

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    wr      = 1'b1;
    addr    = a;
    wr_data = d;
    @(posedge d_clk);
    #1;
    wr = 1'b0;
  endtask

  // rd_data is registered, so it is taken one edge after the strobe
  task automatic bus_read(input reg_addr_t a, output reg_data_t d);
    rd   = 1'b1;
    addr = a;
    @(posedge d_clk);
    #1;
    rd = 1'b0;
    d  = rd_data;
  endtask

  task automatic check_read(input string name, input reg_addr_t a, input reg_data_t exp);
    reg_data_t act;
    bus_read(a, act);
    assert (act == exp) else begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // count reads allow for the synchronizer jitter
  task automatic check_near(input string name, input reg_addr_t a, input int exp,
                            input int tol);
    reg_data_t act;
    bus_read(a, act);
    assert (int'(act) >= exp - tol && int'(act) <= exp + tol) else begin
      errors++;
      $display("ERROR %s: expected %0d +/- %0d, actual %0d", name, exp, tol, act);
    end
  endtask

  task automatic check_irq(input string name, input logic exp);
    assert (irq == exp) else begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, irq);
    end
  endtask

  // wait for n update pulses of one channel
  task automatic wait_update(input int ch, input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < n * update_wait) begin
      @(posedge d_clk);
      #1;
      cycles++;
      if (i_clk_mon_top.updates[ch]) begin
        seen++;
      end
    end
    if (seen < n) begin
      errors++;
      $display("channel %0d gave no update within %0d cycles", ch, n * update_wait);
    end
  endtask

  // ************************************************************
  // watchdog
  // ************************************************************

  initial begin
    repeat (watchdog_cycles) @(posedge d_clk);
    $display("watchdog ran out after %0d cycles, tests did not finish", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  // ************************************************************
  // test sequence
  // ************************************************************

  initial begin
    d_clk      = 1'b0;
    d_rst      = 1'b1;
    meas_clk   = '0;
    rd         = 1'b0;
    wr         = 1'b0;
    addr       = '0;
    wr_data    = '0;
    errors     = 0;
    lfsr_state = 16'd64659;
    repeat (5) @(posedge d_clk);
    #1;
    d_rst = 1'b0;
    check_irq("irq_after_reset", 1'b0);

    // measurement and saturation
    wait_update(0, 1);
    check_near("count_ch0", addr_count_base, win_cycles * d_period / m0_period, 4);
    wait_update(1, 1);
    check_read("count_ch1_saturated", reg_addr_t'(addr_count_base + 1),
               (win_cycles * d_period / m1_period > count_max) ?
               count_max : win_cycles * d_period / m1_period);

    // dead clock reads zero, default limits keep its alarm clear
    wait_update(2, 2);
    idle(2);
    check_read("count_ch2_stopped", reg_addr_t'(addr_count_base + 2), 0);
    check_read("status_default_limits", addr_status, 0);

    // limit registers read back what was written
    for (int ch = 0; ch < num_channels; ch++) begin
      rand_bits(count_width, wr_data);
      low_val = wr_data[count_width-1:0];
      bus_write(reg_addr_t'(addr_low_base + ch), reg_data_t'(low_val));
      check_read("low_readback", reg_addr_t'(addr_low_base + ch), reg_data_t'(low_val));
      rand_bits(count_width, wr_data);
      high_val = wr_data[count_width-1:0];
      bus_write(reg_addr_t'(addr_high_base + ch), reg_data_t'(high_val));
      check_read("high_readback", reg_addr_t'(addr_high_base + ch), reg_data_t'(high_val));
    end
    check_read("unmapped_03", 8'h03, 0);
    check_read("unmapped_3f", 8'h3f, 0);

    // back to defaults, drop whatever the random limits raised
    for (int ch = 0; ch < num_channels; ch++) begin
      bus_write(reg_addr_t'(addr_low_base + ch), 0);
      bus_write(reg_addr_t'(addr_high_base + ch), count_max);
    end
    bus_write(addr_status, (1 << num_channels) - 1);
    check_read("status_cleared", addr_status, 0);
    check_irq("irq_cleared", 1'b0);

    // ************************************************************
    // alarm and irq on channel 0
    // ************************************************************

    bus_write(addr_low_base, 700);
    bus_write(addr_high_base, 800);
    wait_update(0, 1);
    idle(2);
    check_read("alarm_set", addr_status, 1);
    check_irq("irq_set", 1'b1);

    // limits around the real rate, then clear the sticky bit
    bus_write(addr_low_base, 600);
    bus_write(addr_high_base, 680);
    bus_write(addr_status, 1);
    check_read("alarm_clear", addr_status, 0);
    wait_update(0, 2);
    idle(2);
    check_read("alarm_stays_clear", addr_status, 0);
    check_irq("irq_stays_low", 1'b0);

    $display("closing: %0d check errors, %0d assertion failures", errors,
             i_clk_mon_top.i_clk_mon_props.fail_count);
    if (errors == 0 && i_clk_mon_top.i_clk_mon_props.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- clk_mon_top.f
clk_mon_pkg.sv
clk_mon_counter.sv
clk_mon_regs.sv
clk_mon_top.sv
clk_mon_props.sv
clk_mon_tb.sv

//--- Makefile
# verilator build and run of the clock monitor testbench

SRCS := $(shell cat clk_mon_top.f)

.PHONY: all run clean

all: run

obj_dir/Vclk_mon_tb: clk_mon_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module clk_mon_tb \
		-f clk_mon_top.f -o Vclk_mon_tb

# assertion errors must not stop the run before the closing report
run: obj_dir/Vclk_mon_tb
	./obj_dir/Vclk_mon_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
